// ==== Bender.yml ====
package:
  name: trellis_io

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/host_bus_pkg.sv
      - logic/converter_pkg.sv
      - logic/host_decode.sv
      - logic/reset_stretch.sv
      - logic/converter_io.sv
      - logic/read_mux.sv
      - logic/trellis_io_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - bench/trellis_io_props.sv
      - bench/trellis_io_tb.sv

// ==== bench/trellis_io_props.sv ====
`include "trellis_io_defs.svh"

module trellis_io_props (
  input logic ck933,
  input logic rs,
  input logic soft_rs_i,
  input logic dac_rst_i,
  input logic wr_lo_i,
  input logic wr_hi_i,
  input logic cs_n_i,
  input logic rd_n_i,
  input logic rdata_oe_i
);
  timeunit 1ns;
  timeprecision 100ps;

  int fail_count = 0;  // polled by the testbench

  // **************************************************************************
  // reset length
  // **************************************************************************

  hard_reset_len: assert property (@(posedge ck933)
    $fell(rs) |-> dac_rst_i [* `RESET_CYCLES] ##1 !dac_rst_i)
    else begin
      fail_count++;
      $error("system reset after rs has the wrong length");
    end

  soft_reset_len: assert property (@(posedge ck933) disable iff (rs)
    soft_rs_i |=> dac_rst_i [* `RESET_CYCLES] ##1 !dac_rst_i)
    else begin
      fail_count++;
      $error("system reset after a soft reset has the wrong length");
    end

  // **************************************************************************
  // strobes
  // **************************************************************************

  lo_one_cycle: assert property (@(posedge ck933) disable iff (rs) wr_lo_i |=> !wr_lo_i)
    else begin
      fail_count++;
      $error("demod low write strobe longer than one cycle");
    end

  hi_one_cycle: assert property (@(posedge ck933) disable iff (rs) wr_hi_i |=> !wr_hi_i)
    else begin
      fail_count++;
      $error("demod high write strobe longer than one cycle");
    end

  lo_hi_apart: assert property (@(posedge ck933) !(wr_lo_i && wr_hi_i))
    else begin
      fail_count++;
      $error("demod low and high write strobes high together");
    end

  // read enable only inside a host read cycle
  oe_in_read: assert property (@(posedge ck933) rdata_oe_i |-> (!cs_n_i && !rd_n_i))
    else begin
      fail_count++;
      $error("read enable high outside a read cycle");
    end

endmodule

bind trellis_io_top trellis_io_props u_props (
  .ck933      (ck933),
  .rs         (rs),
  .soft_rs_i  (soft_rs),
  .dac_rst_i  (dac_rst_o),
  .wr_lo_i    (demod_wr_lo_o),
  .wr_hi_i    (demod_wr_hi_o),
  .cs_n_i     (host_cs_n_i),
  .rd_n_i     (host_rd_n_i),
  .rdata_oe_i (host_rdata_oe_o)
);

// ==== bench/trellis_io_tb.sv ====
`include "trellis_io_defs.svh"

module trellis_io_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int WAIT_LIMIT = 40;  // cycles, for every wait loop

  logic                       ck933;
  logic                       rs;
  logic                       host_cs_n;
  logic                       host_we_n;
  logic                       host_rd_n;
  logic [`ADDR_W-1:1]         host_addr;
  logic [`HOST_DW-1:0]        host_wdata;
  logic [`HOST_DW-1:0]        host_rdata;
  logic                       host_rdata_oe;
  logic                       demod_en;
  logic                       demod_wr_lo;
  logic                       demod_wr_hi;
  logic [`HOST_DW-1:0]        demod_wdata;
  logic [`DEMOD_DW-1:0]       demod_rdata;
  converter_pkg::adc_sample_t adc_d;
  converter_pkg::adc_sample_t adc_sample;
  converter_pkg::dac_sample_t dac_sample [3];
  logic                       dac_sync   [3];
  converter_pkg::dac_word_t   dac_d      [3];
  logic                       dac_rst;

  // reference model state
  logic                       write_now;
  logic                       in_demod;
  logic                       m_wr_prev;
  logic                       m_pend_lo;
  logic                       m_pend_hi;
  logic                       m_pend_soft;
  logic                       exp_wr_lo;
  logic                       exp_wr_hi;
  logic                       exp_soft;
  int                         exp_rst_cnt;
  converter_pkg::adc_sample_t exp_adc;
  converter_pkg::dac_word_t   exp_dac [3];

  int          lo_pulses = 0;
  int          hi_pulses = 0;
  int          errors = 0;
  logic [31:0] rng;

  trellis_io_top dut_i (
    .ck933           (ck933),
    .rs              (rs),
    .host_cs_n_i     (host_cs_n),
    .host_we_n_i     (host_we_n),
    .host_rd_n_i     (host_rd_n),
    .host_addr_i     (host_addr),
    .host_wdata_i    (host_wdata),
    .host_rdata_o    (host_rdata),
    .host_rdata_oe_o (host_rdata_oe),
    .demod_en_o      (demod_en),
    .demod_wr_lo_o   (demod_wr_lo),
    .demod_wr_hi_o   (demod_wr_hi),
    .demod_wdata_o   (demod_wdata),
    .demod_rdata_i   (demod_rdata),
    .adc_d_i         (adc_d),
    .adc_sample_o    (adc_sample),
    .dac0_sample_i   (dac_sample[0]),
    .dac0_sync_i     (dac_sync[0]),
    .dac1_sample_i   (dac_sample[1]),
    .dac1_sync_i     (dac_sync[1]),
    .dac2_sample_i   (dac_sample[2]),
    .dac2_sync_i     (dac_sync[2]),
    .dac0_d_o        (dac_d[0]),
    .dac1_d_o        (dac_d[1]),
    .dac2_d_o        (dac_d[2]),
    .dac_rst_o       (dac_rst)
  );

  always #10 ck933 = ~ck933;

  // ****************************************************************************
  // reference functions and checks
  // ****************************************************************************

  function automatic logic [31:0] xorshift32(logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [`HOST_DW-1:0] ref_read_data(logic [`ADDR_W-1:1] addr,
                                                       logic [`DEMOD_DW-1:0] rdata);
    logic [`ADDR_W-1:0] byte_addr;
    byte_addr = {addr, 1'b0};
    if (byte_addr == `ADDR_VERSION) begin
      return `VER_NUMBER;
    end
    if (byte_addr[`ADDR_W-1:`ADDR_W-4] == `DEMOD_BASE) begin
      return byte_addr[1] ? rdata[31:16] : rdata[15:0];
    end
    return '0;
  endfunction

  // offset binary is the truncated level plus half the range
  function automatic converter_pkg::dac_word_t ref_dac_word(converter_pkg::dac_sample_t s);
    int level;
    level = s;
    level = level >>> (`SAMPLE_W - `DAC_W);
    return converter_pkg::dac_word_t'(level + (1 << (`DAC_W - 1)));
  endfunction

  task automatic check_value(string what, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      $display("Verification failed");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  task automatic report_timeout(string what);
    $display("Timeout at %0t ns while waiting for %s", $time, what);
    $display("Verification failed");
    $fatal(1, "wait loop timed out");
  endtask

  // ****************************************************************************
  // reference model and comparing process
  // ****************************************************************************

  assign write_now = !host_cs_n && !host_we_n;
  assign in_demod  = host_addr[`ADDR_W-1:`ADDR_W-4] == `DEMOD_BASE;

  always @(posedge ck933 or posedge rs) begin
    if (rs) begin
      m_wr_prev   <= 1'b0;
      m_pend_lo   <= 1'b0;
      m_pend_hi   <= 1'b0;
      m_pend_soft <= 1'b0;
      exp_wr_lo   <= 1'b0;
      exp_wr_hi   <= 1'b0;
      exp_soft    <= 1'b0;
      exp_rst_cnt <= `RESET_CYCLES;
    end else begin
      m_wr_prev   <= write_now;
      m_pend_lo   <= write_now && !m_wr_prev && in_demod && !host_addr[1];
      m_pend_hi   <= write_now && !m_wr_prev && in_demod && host_addr[1];
      m_pend_soft <= write_now && !m_wr_prev && ({host_addr, 1'b0} == `ADDR_RESET);
      exp_wr_lo   <= m_pend_lo;  // pulse one edge after detection
      exp_wr_hi   <= m_pend_hi;
      exp_soft    <= m_pend_soft;
      if (exp_soft) begin
        exp_rst_cnt <= `RESET_CYCLES;
      end else if (exp_rst_cnt != 0) begin
        exp_rst_cnt <= exp_rst_cnt - 1;
      end
    end
  end

  always @(posedge ck933) begin
    exp_adc <= adc_d;
    for (int i = 0; i < 3; i++) begin
      if (rs || exp_rst_cnt != 0) begin
        exp_dac[i] <= '0;
      end else if (dac_sync[i]) begin
        exp_dac[i] <= ref_dac_word(dac_sample[i]);
      end
    end
  end

  always begin
    @(posedge ck933);
    // combinational outputs, inputs settled since the falling edge
    check_value("host_rdata_oe", host_rdata_oe, !host_cs_n && !host_rd_n);
    check_value("host_rdata", host_rdata, ref_read_data(host_addr, demod_rdata));
    check_value("demod_en", demod_en, !host_cs_n && in_demod);
    check_value("demod_wdata", demod_wdata, host_wdata);
    @(negedge ck933);
    // registered outputs
    check_value("adc_sample", adc_sample, exp_adc);
    for (int i = 0; i < 3; i++) begin
      check_value($sformatf("dac%0d_d", i), dac_d[i], exp_dac[i]);
    end
    check_value("demod_wr_lo", demod_wr_lo, exp_wr_lo);
    check_value("demod_wr_hi", demod_wr_hi, exp_wr_hi);
    check_value("dac_rst", dac_rst, rs || exp_rst_cnt != 0);
    check_value("assertion failures", dut_i.u_props.fail_count, 0);
  end

  always @(negedge ck933) begin
    if (demod_wr_lo === 1'b1) lo_pulses <= lo_pulses + 1;
    if (demod_wr_hi === 1'b1) hi_pulses <= hi_pulses + 1;
  end

  // ****************************************************************************
  // stimulus, all on the falling edge
  // ****************************************************************************

  task automatic bus_idle();
    host_cs_n = 1'b1;
    host_we_n = 1'b1;
    host_rd_n = 1'b1;
  endtask

  // counts falling edges while the system reset is high
  task automatic measure_reset(string what, output int cycles);
    cycles = 0;
    while (dac_rst === 1'b1 && cycles < WAIT_LIMIT) begin
      for (int i = 0; i < 3; i++) begin
        if (cycles > 0) check_value("dac word in reset", dac_d[i], '0);
      end
      @(negedge ck933);
      cycles++;
    end
    if (dac_rst === 1'b1) report_timeout(what);
  endtask

  task automatic host_read(logic [`ADDR_W-1:1] addr, logic [`DEMOD_DW-1:0] rdata,
                           output logic [`HOST_DW-1:0] data);
    host_addr   = addr;
    demod_rdata = rdata;
    host_cs_n   = 1'b0;
    host_rd_n   = 1'b0;
    @(posedge ck933);
    check_value("read enable in read", host_rdata_oe, 1);
    data = host_rdata;
    @(negedge ck933);
    bus_idle();
  endtask

  task automatic host_write(logic [`ADDR_W-1:1] addr, logic [`HOST_DW-1:0] data, int hold);
    host_addr  = addr;
    host_wdata = data;
    host_cs_n  = 1'b0;
    host_we_n  = 1'b0;
    repeat (hold) @(negedge ck933);
    bus_idle();
  endtask

  task automatic run_random(int cycles);
    for (int c = 0; c < cycles; c++) begin
      rng   = xorshift32(rng);
      adc_d = rng[13:0];
      for (int i = 0; i < 3; i++) begin
        dac_sync[i] = rng[14+i];
      end
      for (int i = 0; i < 3; i++) begin
        rng           = xorshift32(rng);
        dac_sample[i] = rng[17:0];
      end
      rng         = xorshift32(rng);
      demod_rdata = rng;
      rng         = xorshift32(rng);
      host_cs_n   = rng[0] & rng[1];  // mostly selected
      host_rd_n   = rng[2] & rng[3];
      host_wdata  = rng[31:16];
      case (rng[5:4])
        2'd0:    host_addr = 11'(`ADDR_VERSION >> 1);
        2'd1,
        2'd2:    host_addr = {`DEMOD_BASE, rng[12:6]};
        default: host_addr = rng[22:12];  // anywhere, mostly unmapped
      endcase
      @(negedge ck933);
    end
    bus_idle();
  endtask

  initial begin
    int                  n;
    int                  hold;
    int                  lo_start;
    int                  hi_start;
    logic [`ADDR_W-1:1]  addr;
    logic [`HOST_DW-1:0] data;

    ck933       = 1'b0;
    rs          = 1'b1;
    host_addr   = '0;
    host_wdata  = '0;
    demod_rdata = '0;
    adc_d       = '0;
    for (int i = 0; i < 3; i++) begin
      dac_sample[i] = '0;
      dac_sync[i]   = 1'b0;
    end
    bus_idle();
    rng = 32'h5917964b;

    repeat (2) @(negedge ck933);
    rs = 1'b0;
    measure_reset("release of the hard reset", n);
    check_value("hard reset length", n, `RESET_CYCLES);

    rng = xorshift32(rng);
    host_read(11'(`ADDR_VERSION >> 1), rng, data);
    check_value("version register", data, `VER_NUMBER);

    // demod writes, held for a random number of cycles
    for (int k = 0; k < 10; k++) begin
      rng      = xorshift32(rng);
      addr     = {`DEMOD_BASE, rng[6:0]};
      hold     = 1 + int'(rng[10:7]) % 10;
      lo_start = lo_pulses;
      hi_start = hi_pulses;
      host_write(addr, rng[31:16], hold);
      n = 0;
      while (lo_pulses + hi_pulses == lo_start + hi_start && n < WAIT_LIMIT) begin
        @(negedge ck933);
        n++;
      end
      if (lo_pulses + hi_pulses == lo_start + hi_start) report_timeout("demod write strobe");
      repeat (3) @(negedge ck933);
      check_value("low strobe pulses", lo_pulses - lo_start, addr[1] ? 0 : 1);
      check_value("high strobe pulses", hi_pulses - hi_start, addr[1] ? 1 : 0);
    end

    run_random(300);

    // soft reset through the misc register
    host_addr  = 11'(`ADDR_RESET >> 1);
    host_cs_n  = 1'b0;
    host_we_n  = 1'b0;
    @(negedge ck933);
    bus_idle();
    n = 1;
    while (dac_rst !== 1'b1 && n < WAIT_LIMIT) begin
      @(negedge ck933);
      n++;
    end
    if (dac_rst !== 1'b1) report_timeout("soft reset");
    check_value("soft reset start", n, 3);  // detect, pulse, then reset
    measure_reset("release of the soft reset", n);
    check_value("soft reset length", n, `RESET_CYCLES);

    run_random(100);
    repeat (4) @(negedge ck933);

    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// ==== logic/converter_io.sv ====
`include "trellis_io_defs.svh"

module converter_io (
  input  logic                      ck933,
  input  logic                      sys_rst_i,
  input  converter_pkg::adc_sample_t adc_d_i,
  input  converter_pkg::dac_sample_t dac0_sample_i,
  input  logic                      dac0_sync_i,
  input  converter_pkg::dac_sample_t dac1_sample_i,
  input  logic                      dac1_sync_i,
  input  converter_pkg::dac_sample_t dac2_sample_i,
  input  logic                      dac2_sync_i,
  output converter_pkg::adc_sample_t adc_sample_o,
  output converter_pkg::dac_word_t   dac0_d_o,
  output converter_pkg::dac_word_t   dac1_d_o,
  output converter_pkg::dac_word_t   dac2_d_o
);

  localparam int NUM_DAC = 3;
  localparam int LSB     = `SAMPLE_W - `DAC_W;  // bits dropped from each sample

  converter_pkg::dac_sample_t dac_sample [NUM_DAC];
  logic                       dac_sync   [NUM_DAC];

  // ****************************************************************************
  // adc capture
  // ****************************************************************************

  always_ff @(posedge ck933) begin
    adc_sample_o <= adc_d_i;  // meant to land in the io flops
  end

  // ****************************************************************************
  // dac channels
  // ****************************************************************************

  assign dac_sample[0] = dac0_sample_i;
  assign dac_sample[1] = dac1_sample_i;
  assign dac_sample[2] = dac2_sample_i;
  assign dac_sync[0]   = dac0_sync_i;
  assign dac_sync[1]   = dac1_sync_i;
  assign dac_sync[2]   = dac2_sync_i;

  for (genvar ch = 0; ch < NUM_DAC; ch++) begin : g_dac
    converter_pkg::dac_word_t word_q;

    // truncate, then flip the sign bit for offset binary
    always_ff @(posedge ck933) begin
      if (sys_rst_i) begin
        word_q <= '0;
      end else if (dac_sync[ch]) begin
        word_q <= {~dac_sample[ch][`SAMPLE_W-1], dac_sample[ch][`SAMPLE_W-2:LSB]};
      end
    end
  end

  assign dac0_d_o = g_dac[0].word_q;
  assign dac1_d_o = g_dac[1].word_q;
  assign dac2_d_o = g_dac[2].word_q;

endmodule

// ==== logic/converter_pkg.sv ====
`include "trellis_io_defs.svh"

package converter_pkg;

  // captured adc word, straight from the pins
  typedef logic [`ADC_W-1:0] adc_sample_t;

  // two's complement sample from the demod
  typedef logic signed [`SAMPLE_W-1:0] dac_sample_t;

  // offset binary, msb inverted
  typedef logic [`DAC_W-1:0] dac_word_t;

endpackage

// ==== logic/host_bus_pkg.sv ====
`include "trellis_io_defs.svh"

package host_bus_pkg;

  // address space selected by addr[11:8]
  typedef enum logic [1:0] {
    SPACE_NONE,
    SPACE_MISC,
    SPACE_DEMOD
  } space_e;

  // register inside the misc space
  typedef enum logic [1:0] {
    MISC_RESET,
    MISC_VERSION,
    MISC_OTHER
  } misc_reg_e;

endpackage

// ==== logic/host_decode.sv ====
`include "trellis_io_defs.svh"

module host_decode (
  input  logic                    ck933,
  input  logic                    rs,
  input  logic                    host_cs_n_i,
  input  logic                    host_we_n_i,
  input  logic [`ADDR_W-1:1]      host_addr_i,
  output host_bus_pkg::space_e    space_o,
  output host_bus_pkg::misc_reg_e misc_reg_o,
  output logic                    addr_hi_o,
  output logic                    soft_rs_o,
  output logic                    demod_en_o,
  output logic                    demod_wr_lo_o,
  output logic                    demod_wr_hi_o
);

  logic [`ADDR_W-1:0] byte_addr;
  logic               wr_now;     // write strobes both low this cycle
  logic               wr_q;
  logic               wr_qq;
  logic               wr_edge;
  logic               wr_demod_q;
  logic               wr_reset_q;
  logic               wr_hi_q;

  assign byte_addr = {host_addr_i, 1'b0};  // bit 0 is never driven
  assign addr_hi_o = byte_addr[1];

  // ****************************************************************************
  // address decode
  // ****************************************************************************

  always_comb begin
    case (byte_addr[`ADDR_W-1:`ADDR_W-4])
      `MISC_BASE:  space_o = host_bus_pkg::SPACE_MISC;
      `DEMOD_BASE: space_o = host_bus_pkg::SPACE_DEMOD;
      default:     space_o = host_bus_pkg::SPACE_NONE;
    endcase
  end

  // full address compare, so only meaningful inside the misc space
  always_comb begin
    case (byte_addr)
      `ADDR_RESET:   misc_reg_o = host_bus_pkg::MISC_RESET;
      `ADDR_VERSION: misc_reg_o = host_bus_pkg::MISC_VERSION;
      default:       misc_reg_o = host_bus_pkg::MISC_OTHER;
    endcase
  end

  // chip select qualified space for the external demod
  assign demod_en_o = ~host_cs_n_i && (space_o == host_bus_pkg::SPACE_DEMOD);

  // ****************************************************************************
  // write edge and strobes
  // ****************************************************************************

  assign wr_now  = ~host_cs_n_i & ~host_we_n_i;
  assign wr_edge = wr_q & ~wr_qq;  // first sampled cycle of a write

  always_ff @(posedge ck933 or posedge rs) begin
    if (rs) begin
      wr_q  <= 1'b0;
      wr_qq <= 1'b0;
    end else begin
      wr_q  <= wr_now;
      wr_qq <= wr_q;
    end
  end

  // target of the write, captured along with the strobe sample
  always_ff @(posedge ck933) begin
    wr_demod_q <= (space_o == host_bus_pkg::SPACE_DEMOD);
    wr_reset_q <= (space_o == host_bus_pkg::SPACE_MISC) &&
                  (misc_reg_o == host_bus_pkg::MISC_RESET);
    wr_hi_q    <= byte_addr[1];
  end

  // one-cycle pulses, a cycle after the edge is seen
  always_ff @(posedge ck933 or posedge rs) begin
    if (rs) begin
      soft_rs_o     <= 1'b0;
      demod_wr_lo_o <= 1'b0;
      demod_wr_hi_o <= 1'b0;
    end else begin
      soft_rs_o     <= wr_edge & wr_reset_q;
      demod_wr_lo_o <= wr_edge & wr_demod_q & ~wr_hi_q;
      demod_wr_hi_o <= wr_edge & wr_demod_q & wr_hi_q;
    end
  end

endmodule

// ==== logic/read_mux.sv ====
`include "trellis_io_defs.svh"

module read_mux (
  input  logic                    host_cs_n_i,
  input  logic                    host_rd_n_i,
  input  host_bus_pkg::space_e    space_i,
  input  host_bus_pkg::misc_reg_e misc_reg_i,
  input  logic                    addr_hi_i,
  input  logic [`DEMOD_DW-1:0]    demod_rdata_i,
  output logic [`HOST_DW-1:0]     host_rdata_o,
  output logic                    host_rdata_oe_o
);

  // ****************************************************************************
  // host read data
  // ****************************************************************************

  always_comb begin
    host_rdata_o = '0;  // unmapped reads give zero
    case (space_i)
      host_bus_pkg::SPACE_MISC: begin
        if (misc_reg_i == host_bus_pkg::MISC_VERSION) begin
          host_rdata_o = `VER_NUMBER;
        end
      end
      host_bus_pkg::SPACE_DEMOD: begin
        // 32-bit demod word read as two half-words
        if (addr_hi_i) begin
          host_rdata_o = demod_rdata_i[`DEMOD_DW-1:`HOST_DW];
        end else begin
          host_rdata_o = demod_rdata_i[`HOST_DW-1:0];
        end
      end
      default: begin
        host_rdata_o = '0;
      end
    endcase
  end

  // drives the board data buffers
  assign host_rdata_oe_o = ~host_cs_n_i & ~host_rd_n_i;

endmodule

// ==== logic/reset_stretch.sv ====
`include "trellis_io_defs.svh"

module reset_stretch (
  input  logic ck933,
  input  logic rs,
  input  logic soft_rs_i,
  output logic sys_rst_o
);

  localparam int CNT_W = $clog2(`RESET_CYCLES + 1);
  localparam logic [CNT_W-1:0] CNT_LOAD = CNT_W'(`RESET_CYCLES);

  logic [CNT_W-1:0] count;

  // loaded on hard reset and on a soft reset pulse, then runs down to zero
  always_ff @(posedge ck933 or posedge rs) begin
    if (rs) begin
      count <= CNT_LOAD;
    end else if (soft_rs_i) begin
      count <= CNT_LOAD;
    end else if (count != '0) begin
      count <= count - 1'b1;
    end
  end

  // also the dac reset pin
  assign sys_rst_o = rs | (count != '0);

endmodule

// ==== logic/trellis_io_defs.svh ====
`ifndef TRELLIS_IO_DEFS_SVH
`define TRELLIS_IO_DEFS_SVH

// ****************************************************************************
// version and widths
// ****************************************************************************

`define VER_NUMBER    16'h0032    // read-only version register value

`define ADDR_W        12          // host byte address
`define HOST_DW       16          // host data bus
`define DEMOD_DW      32          // demod register read word
`define ADC_W         14          // adc pins
`define SAMPLE_W      18          // signed demod sample to the dacs
`define DAC_W         14          // offset-binary dac word

// length of the stretched system reset, in ck933 cycles
`define RESET_CYCLES  6

// ****************************************************************************
// address map
// ****************************************************************************

// space prefixes, compared against addr[11:8]
`define MISC_BASE     4'h0
`define DEMOD_BASE    4'h1

// misc register byte addresses
`define ADDR_RESET    12'h000     // write triggers soft reset
`define ADDR_VERSION  12'h002

`endif

// ==== logic/trellis_io_top.sv ====
`include "trellis_io_defs.svh"

module trellis_io_top (
  input  logic                       ck933,
  input  logic                       rs,
  // host bus
  input  logic                       host_cs_n_i,
  input  logic                       host_we_n_i,
  input  logic                       host_rd_n_i,
  input  logic [`ADDR_W-1:1]         host_addr_i,
  input  logic [`HOST_DW-1:0]        host_wdata_i,
  output logic [`HOST_DW-1:0]        host_rdata_o,
  output logic                       host_rdata_oe_o,
  // external demod register space
  output logic                       demod_en_o,
  output logic                       demod_wr_lo_o,
  output logic                       demod_wr_hi_o,
  output logic [`HOST_DW-1:0]        demod_wdata_o,
  input  logic [`DEMOD_DW-1:0]       demod_rdata_i,
  // converters
  input  converter_pkg::adc_sample_t adc_d_i,
  output converter_pkg::adc_sample_t adc_sample_o,
  input  converter_pkg::dac_sample_t dac0_sample_i,
  input  logic                       dac0_sync_i,
  input  converter_pkg::dac_sample_t dac1_sample_i,
  input  logic                       dac1_sync_i,
  input  converter_pkg::dac_sample_t dac2_sample_i,
  input  logic                       dac2_sync_i,
  output converter_pkg::dac_word_t   dac0_d_o,
  output converter_pkg::dac_word_t   dac1_d_o,
  output converter_pkg::dac_word_t   dac2_d_o,
  output logic                       dac_rst_o
);

  host_bus_pkg::space_e    space;
  host_bus_pkg::misc_reg_e misc_reg;
  logic                    addr_hi;
  logic                    soft_rs;
  logic                    sys_rst;

  assign demod_wdata_o = host_wdata_i;  // demod sees the host write bus
  assign dac_rst_o     = sys_rst;

  host_decode u_host_decode (
    .ck933         (ck933),
    .rs            (rs),            // hard reset only
    .host_cs_n_i   (host_cs_n_i),
    .host_we_n_i   (host_we_n_i),
    .host_addr_i   (host_addr_i),
    .space_o       (space),
    .misc_reg_o    (misc_reg),
    .addr_hi_o     (addr_hi),
    .soft_rs_o     (soft_rs),
    .demod_en_o    (demod_en_o),
    .demod_wr_lo_o (demod_wr_lo_o),
    .demod_wr_hi_o (demod_wr_hi_o)
  );

  reset_stretch u_reset_stretch (
    .ck933     (ck933),
    .rs        (rs),
    .soft_rs_i (soft_rs),
    .sys_rst_o (sys_rst)
  );

  converter_io u_converter_io (
    .ck933         (ck933),
    .sys_rst_i     (sys_rst),
    .adc_d_i       (adc_d_i),
    .dac0_sample_i (dac0_sample_i),
    .dac0_sync_i   (dac0_sync_i),
    .dac1_sample_i (dac1_sample_i),
    .dac1_sync_i   (dac1_sync_i),
    .dac2_sample_i (dac2_sample_i),
    .dac2_sync_i   (dac2_sync_i),
    .adc_sample_o  (adc_sample_o),
    .dac0_d_o      (dac0_d_o),
    .dac1_d_o      (dac1_d_o),
    .dac2_d_o      (dac2_d_o)
  );

  read_mux u_read_mux (
    .host_cs_n_i     (host_cs_n_i),
    .host_rd_n_i     (host_rd_n_i),
    .space_i         (space),
    .misc_reg_i      (misc_reg),
    .addr_hi_i       (addr_hi),
    .demod_rdata_i   (demod_rdata_i),
    .host_rdata_o    (host_rdata_o),
    .host_rdata_oe_o (host_rdata_oe_o)
  );

endmodule

// ==== sources.f ====
+incdir+logic
logic/host_bus_pkg.sv
logic/converter_pkg.sv
logic/host_decode.sv
logic/reset_stretch.sv
logic/converter_io.sv
logic/read_mux.sv
logic/trellis_io_top.sv
bench/trellis_io_props.sv
bench/trellis_io_tb.sv
